// ==== verilog/csr_types_pkg.sv ====
package csr_types_pkg;

    typedef logic [31:0] csr_data_t;
    typedef logic [11:0] csr_addr_t;
    typedef logic [2:0]  csr_cmd_t;

    // Request from the core, 47 bits
    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        csr_data_t wdata;
    } csr_req_t;

    // Registered response, 33 bits
    typedef struct packed {
        csr_data_t rdata;
        logic      invalid;   // Unmapped address or write to read-only region
    } csr_rsp_t;

    // Write broadcast to every datapath block
    typedef struct packed {
        logic      we;
        csr_addr_t addr;
        csr_data_t wdata;     // Already merged for set and clear
    } csr_wr_t;

    typedef struct packed {
        logic      hit;
        csr_data_t rdata;     // Zero when not hit
    } csr_rd_t;

endpackage

// ==== verilog/csr_map_pkg.sv ====
package csr_map_pkg;

    import csr_types_pkg::*;

    // Access commands, zero is not a valid command
    localparam csr_cmd_t CMD_READ       = 3'd1;
    localparam csr_cmd_t CMD_WRITE      = 3'd2;
    localparam csr_cmd_t CMD_READ_WRITE = 3'd3;
    localparam csr_cmd_t CMD_READ_SET   = 3'd4;
    localparam csr_cmd_t CMD_READ_CLEAR = 3'd5;

    // Machine-mode address map
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID   = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID    = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID   = 12'hF14;
    localparam csr_addr_t ADDR_MSTATUS   = 12'h300;
    localparam csr_addr_t ADDR_MIE       = 12'h304;
    localparam csr_addr_t ADDR_MTVEC     = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH  = 12'h340;
    localparam csr_addr_t ADDR_MEPC      = 12'h341;
    localparam csr_addr_t ADDR_MCAUSE    = 12'h342;
    localparam csr_addr_t ADDR_MIP       = 12'h344;
    localparam csr_addr_t ADDR_MCYCLE    = 12'hB00;
    localparam csr_addr_t ADDR_MCYCLEH   = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRET  = 12'hB02;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;

    localparam logic [1:0] RO_REGION_CODE = 2'b11;  // addr[11:10]

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;
    localparam int MSTATUS_MPP_LSB  = 11;
    localparam logic [1:0] MPP_RESERVED = 2'b10;

    // Same positions in mie and mip
    localparam int IRQ_EXT_BIT   = 11;
    localparam int IRQ_TIMER_BIT = 7;
    localparam int IRQ_SW_BIT    = 3;

    localparam csr_data_t MVENDORID_VALUE = 32'h0A1AA1E0;
    localparam csr_data_t MARCHID_VALUE   = 32'h0000_0001;

    // Reset values
    localparam logic [1:0] MPP_RESET   = 2'b00;
    localparam csr_data_t  MTVEC_RESET = 32'h0000_0000;

endpackage

// ==== verilog/csr_access_ctrl.sv ====
`timescale 1ns/1ps

module csr_access_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid_i,
    input  csr_types_pkg::csr_req_t   req_i,
    output logic                      req_ready_o,
    output logic                      rsp_valid_o,
    input  logic                      rsp_ready_i,
    output csr_types_pkg::csr_rsp_t   rsp_o,
    input  csr_types_pkg::csr_rd_t    regs_rd_i,
    input  csr_types_pkg::csr_rd_t    cnt_rd_i,
    input  csr_types_pkg::csr_rd_t    irq_rd_i,
    output csr_types_pkg::csr_wr_t    wr_o,
    output csr_types_pkg::csr_addr_t  rd_addr_o
);
    import csr_types_pkg::*;
    import csr_map_pkg::*;

    typedef enum logic {
        SLOT_EMPTY,
        SLOT_FULL
    } slot_state_e;

    slot_state_e state_q;
    slot_state_e state_d;
    logic        accept;
    logic        is_read;
    logic        is_write;
    logic        hit;
    logic        ro_write;
    logic        invalid;
    csr_data_t   rdata;
    csr_data_t   wdata_final;
    csr_rsp_t    rsp_q;

    // Command decode
    always_comb begin
        is_read  = 1'b0;
        is_write = 1'b0;
        case (req_i.cmd)
            CMD_READ:  is_read = 1'b1;
            CMD_WRITE: is_write = 1'b1;
            CMD_READ_WRITE, CMD_READ_SET, CMD_READ_CLEAR: begin
                is_read  = 1'b1;
                is_write = 1'b1;
            end
            default: ;  // Unknown code is flagged below
        endcase
    end

    assign rd_addr_o = req_i.addr;
    assign hit       = regs_rd_i.hit | cnt_rd_i.hit | irq_rd_i.hit;
    assign rdata     = regs_rd_i.rdata | cnt_rd_i.rdata | irq_rd_i.rdata;

    assign ro_write = is_write && (req_i.addr[11:10] == RO_REGION_CODE);
    assign invalid  = !hit || ro_write || !(is_read || is_write);

    // Read-modify-write merge
    always_comb begin
        case (req_i.cmd)
            CMD_READ_SET:   wdata_final = rdata | req_i.wdata;
            CMD_READ_CLEAR: wdata_final = rdata & ~req_i.wdata;
            default:        wdata_final = req_i.wdata;
        endcase
    end

    assign req_ready_o = (state_q == SLOT_EMPTY) || rsp_ready_i;
    assign accept      = req_valid_i && req_ready_o;

    always_comb begin
        wr_o.we    = accept && is_write && !invalid;
        wr_o.addr  = req_i.addr;
        wr_o.wdata = wdata_final;
    end

    // Response slot FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            SLOT_EMPTY: if (accept) state_d = SLOT_FULL;
            SLOT_FULL:  if (rsp_ready_i && !accept) state_d = SLOT_EMPTY;
            default:    state_d = SLOT_EMPTY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= SLOT_EMPTY;
        end else begin
            state_q <= state_d;
        end
    end

    // Old register value captured on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_q.rdata   <= rdata;
            rsp_q.invalid <= invalid;
        end
    end

    assign rsp_valid_o = (state_q == SLOT_FULL);
    assign rsp_o       = rsp_q;

    // A write always leaves a valid response in the slot
    a_we_fills_slot: assert property (@(posedge clk) disable iff (!rst_n)
        wr_o.we |=> rsp_valid_o && !rsp_o.invalid);

    // Address decodes of the three datapath blocks must not overlap
    a_single_hit: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({regs_rd_i.hit, cnt_rd_i.hit, irq_rd_i.hit}));

endmodule

// ==== verilog/csr_machine_regs.sv ====
`timescale 1ns/1ps

module csr_machine_regs #(
    parameter csr_types_pkg::csr_data_t MIMPID  = 32'h0000_0001,
    parameter csr_types_pkg::csr_data_t MHARTID = 32'h0000_0000
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  csr_types_pkg::csr_wr_t    wr_i,
    input  csr_types_pkg::csr_addr_t  rd_addr_i,
    output csr_types_pkg::csr_rd_t    rd_o,
    output logic                      mstatus_mie_o
);
    import csr_types_pkg::*;
    import csr_map_pkg::*;

    logic       mie_q;
    logic       mpie_q;
    logic [1:0] mpp_q;
    csr_data_t  mtvec_q;
    csr_data_t  mscratch_q;
    csr_data_t  mepc_q;
    csr_data_t  mcause_q;
    csr_data_t  mstatus_rd;
    csr_data_t  wdata;
    logic [1:0] wr_mpp;
    logic       wr_aligned;
    logic       wr_mstatus;
    logic       wr_mtvec;
    logic       wr_mscratch;
    logic       wr_mepc;
    logic       wr_mcause;

    assign wdata      = wr_i.wdata;
    assign wr_mpp     = wdata[MSTATUS_MPP_LSB +: 2];
    assign wr_aligned = (wdata[1:0] == 2'b00);  // Word-aligned target

    assign wr_mstatus  = wr_i.we && (wr_i.addr == ADDR_MSTATUS);
    assign wr_mtvec    = wr_i.we && (wr_i.addr == ADDR_MTVEC);
    assign wr_mscratch = wr_i.we && (wr_i.addr == ADDR_MSCRATCH);
    assign wr_mepc     = wr_i.we && (wr_i.addr == ADDR_MEPC);
    assign wr_mcause   = wr_i.we && (wr_i.addr == ADDR_MCAUSE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mie_q      <= 1'b0;
            mpie_q     <= 1'b0;
            mpp_q      <= MPP_RESET;
            mtvec_q    <= MTVEC_RESET;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else begin
            if (wr_mstatus) begin
                mie_q  <= wdata[MSTATUS_MIE_BIT];
                mpie_q <= wdata[MSTATUS_MPIE_BIT];
                if (wr_mpp != MPP_RESERVED)
                    mpp_q <= wr_mpp;  // Reserved encoding keeps old MPP
            end
            if (wr_mtvec && wr_aligned)
                mtvec_q <= wdata;
            if (wr_mscratch)
                mscratch_q <= wdata;
            if (wr_mepc && wr_aligned)
                mepc_q <= wdata;
            if (wr_mcause)
                mcause_q <= wdata;
        end
    end

    // Only the kept mstatus fields, rest reads zero
    always_comb begin
        mstatus_rd = '0;
        mstatus_rd[MSTATUS_MIE_BIT]        = mie_q;
        mstatus_rd[MSTATUS_MPIE_BIT]       = mpie_q;
        mstatus_rd[MSTATUS_MPP_LSB +: 2]   = mpp_q;
    end

    always_comb begin
        rd_o     = '0;
        rd_o.hit = 1'b1;
        case (rd_addr_i)
            ADDR_MVENDORID: rd_o.rdata = MVENDORID_VALUE;
            ADDR_MARCHID:   rd_o.rdata = MARCHID_VALUE;
            ADDR_MIMPID:    rd_o.rdata = MIMPID;
            ADDR_MHARTID:   rd_o.rdata = MHARTID;
            ADDR_MSTATUS:   rd_o.rdata = mstatus_rd;
            ADDR_MTVEC:     rd_o.rdata = mtvec_q;
            ADDR_MSCRATCH:  rd_o.rdata = mscratch_q;
            ADDR_MEPC:      rd_o.rdata = mepc_q;
            ADDR_MCAUSE:    rd_o.rdata = mcause_q;
            default:        rd_o.hit = 1'b0;
        endcase
    end

    assign mstatus_mie_o = mie_q;  // Global enable for the irq unit

    a_mpp_legal: assert property (@(posedge clk) disable iff (!rst_n)
        mpp_q != MPP_RESERVED);

endmodule

// ==== verilog/csr_counters.sv ====
`timescale 1ns/1ps

module csr_counters (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      instret_incr_i,
    input  csr_types_pkg::csr_wr_t    wr_i,
    input  csr_types_pkg::csr_addr_t  rd_addr_i,
    output csr_types_pkg::csr_rd_t    rd_o
);
    import csr_types_pkg::*;
    import csr_map_pkg::*;

    logic [63:0] mcycle_q;
    logic [63:0] minstret_q;

    // A word write wins over the increment in the same cycle
    function automatic logic [63:0] count_next(
        input logic [63:0] cur,
        input logic        inc,
        input logic        wr_lo,
        input logic        wr_hi,
        input csr_data_t   wdata
    );
        logic [63:0] nxt;
        nxt = cur;
        if (wr_lo)
            nxt[31:0] = wdata;
        else if (wr_hi)
            nxt[63:32] = wdata;
        else if (inc)
            nxt = cur + 64'd1;  // Carry into the high word
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mcycle_q   <= '0;
            minstret_q <= '0;
        end else begin
            mcycle_q <= count_next(mcycle_q, 1'b1,
                wr_i.we && (wr_i.addr == ADDR_MCYCLE),
                wr_i.we && (wr_i.addr == ADDR_MCYCLEH), wr_i.wdata);
            minstret_q <= count_next(minstret_q, instret_incr_i,
                wr_i.we && (wr_i.addr == ADDR_MINSTRET),
                wr_i.we && (wr_i.addr == ADDR_MINSTRETH), wr_i.wdata);
        end
    end

    always_comb begin
        rd_o     = '0;
        rd_o.hit = 1'b1;
        case (rd_addr_i)
            ADDR_MCYCLE:    rd_o.rdata = mcycle_q[31:0];
            ADDR_MCYCLEH:   rd_o.rdata = mcycle_q[63:32];
            ADDR_MINSTRET:  rd_o.rdata = minstret_q[31:0];
            ADDR_MINSTRETH: rd_o.rdata = minstret_q[63:32];
            default:        rd_o.hit = 1'b0;
        endcase
    end

endmodule

// ==== verilog/csr_irq_unit.sv ====
`timescale 1ns/1ps

module csr_irq_unit (
    input  logic                      clk,
    input  logic                      rst_n,
    input  csr_types_pkg::csr_wr_t    wr_i,
    input  csr_types_pkg::csr_addr_t  rd_addr_i,
    output csr_types_pkg::csr_rd_t    rd_o,
    input  logic                      mstatus_mie_i,
    input  logic                      irq_ext_i,
    input  logic                      irq_timer_i,
    input  logic                      irq_sw_i,
    output logic                      irq_pending_o
);
    import csr_types_pkg::*;
    import csr_map_pkg::*;

    logic      meie_q;
    logic      mtie_q;
    logic      msie_q;
    csr_data_t mie_rd;
    csr_data_t mip_rd;

    // Only mie is writable, mip writes are dropped
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            meie_q <= 1'b0;
            mtie_q <= 1'b0;
            msie_q <= 1'b0;
        end else if (wr_i.we && (wr_i.addr == ADDR_MIE)) begin
            meie_q <= wr_i.wdata[IRQ_EXT_BIT];
            mtie_q <= wr_i.wdata[IRQ_TIMER_BIT];
            msie_q <= wr_i.wdata[IRQ_SW_BIT];
        end
    end

    always_comb begin
        mie_rd = '0;
        mie_rd[IRQ_EXT_BIT]   = meie_q;
        mie_rd[IRQ_TIMER_BIT] = mtie_q;
        mie_rd[IRQ_SW_BIT]    = msie_q;
        mip_rd = '0;
        mip_rd[IRQ_EXT_BIT]   = irq_ext_i;    // Live line, no latch
        mip_rd[IRQ_TIMER_BIT] = irq_timer_i;
        mip_rd[IRQ_SW_BIT]    = irq_sw_i;
    end

    always_comb begin
        rd_o     = '0;
        rd_o.hit = 1'b1;
        case (rd_addr_i)
            ADDR_MIE: rd_o.rdata = mie_rd;
            ADDR_MIP: rd_o.rdata = mip_rd;
            default:  rd_o.hit = 1'b0;
        endcase
    end

    assign irq_pending_o = mstatus_mie_i &&
        ((meie_q && irq_ext_i) || (mtie_q && irq_timer_i) || (msie_q && irq_sw_i));

endmodule

// ==== verilog/csr_top.sv ====
`timescale 1ns/1ps

module csr_top #(
    parameter csr_types_pkg::csr_data_t MIMPID  = 32'h0000_0001,
    parameter csr_types_pkg::csr_data_t MHARTID = 32'h0000_0000
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  csr_types_pkg::csr_req_t  req_i,
    output logic                     rsp_valid_o,
    input  logic                     rsp_ready_i,
    output csr_types_pkg::csr_rsp_t  rsp_o,
    input  logic                     instret_incr_i,
    input  logic                     irq_ext_i,
    input  logic                     irq_timer_i,
    input  logic                     irq_sw_i,
    output logic                     irq_pending_o
);
    import csr_types_pkg::*;

    csr_wr_t   wr;
    csr_addr_t rd_addr;
    csr_rd_t   regs_rd;
    csr_rd_t   cnt_rd;
    csr_rd_t   irq_rd;
    logic      mstatus_mie;

    csr_access_ctrl u_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid_i (req_valid_i),
        .req_i       (req_i),
        .req_ready_o (req_ready_o),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_o       (rsp_o),
        .regs_rd_i   (regs_rd),
        .cnt_rd_i    (cnt_rd),
        .irq_rd_i    (irq_rd),
        .wr_o        (wr),
        .rd_addr_o   (rd_addr)
    );

    csr_machine_regs #(
        .MIMPID  (MIMPID),
        .MHARTID (MHARTID)
    ) u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_i          (wr),
        .rd_addr_i     (rd_addr),
        .rd_o          (regs_rd),
        .mstatus_mie_o (mstatus_mie)
    );

    csr_counters u_counters (
        .clk            (clk),
        .rst_n          (rst_n),
        .instret_incr_i (instret_incr_i),
        .wr_i           (wr),
        .rd_addr_i      (rd_addr),
        .rd_o           (cnt_rd)
    );

    csr_irq_unit u_irq (
        .clk           (clk),
        .rst_n         (rst_n),
        .wr_i          (wr),
        .rd_addr_i     (rd_addr),
        .rd_o          (irq_rd),
        .mstatus_mie_i (mstatus_mie),
        .irq_ext_i     (irq_ext_i),
        .irq_timer_i   (irq_timer_i),
        .irq_sw_i      (irq_sw_i),
        .irq_pending_o (irq_pending_o)
    );

endmodule

// ==== tb/csr_tb.sv ====
`timescale 1ns/1ps

module csr_tb;
    import csr_types_pkg::*;
    import csr_map_pkg::*;

    localparam csr_data_t TB_MIMPID   = 32'h0000_0203;
    localparam csr_data_t TB_MHARTID  = 32'h0000_0005;
    localparam int        SEED        = 31510;
    localparam int        TIMEOUT_CYC = 200;

    logic      clk;
    logic      rst_n;
    logic      req_valid_i;
    logic      req_ready_o;
    csr_req_t  req_i;
    logic      rsp_valid_o;
    logic      rsp_ready_i;
    csr_rsp_t  rsp_o;
    logic      instret_incr_i;
    logic      irq_ext_i;
    logic      irq_timer_i;
    logic      irq_sw_i;
    logic      irq_pending_o;

    csr_data_t model [0:4095];  // Expected register contents by address
    int        errors       = 0;
    int        tests_passed = 0;
    int        tests_failed = 0;
    int        n_issued     = 0;
    int        n_accepted   = 0;
    int        n_responses  = 0;
    bit        timeout_hit  = 1'b0;
    bit        bp_random    = 1'b0;
    bit        bp_hold      = 1'b1;  // rsp_ready_i level when not random

    csr_top #(
        .MIMPID  (TB_MIMPID),
        .MHARTID (TB_MHARTID)
    ) u_csr_top (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_i          (req_i),
        .rsp_valid_o    (rsp_valid_o),
        .rsp_ready_i    (rsp_ready_i),
        .rsp_o          (rsp_o),
        .instret_incr_i (instret_incr_i),
        .irq_ext_i      (irq_ext_i),
        .irq_timer_i    (irq_timer_i),
        .irq_sw_i       (irq_sw_i),
        .irq_pending_o  (irq_pending_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Response consumer with random stalls
    initial begin
        rsp_ready_i = 1'b1;
        forever begin
            @(posedge clk);
            rsp_ready_i <= bp_random ? (($urandom % 4) != 0) : bp_hold;
        end
    end

    // Handshake counters sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (req_valid_i && req_ready_o)
                n_accepted++;
            if (rsp_valid_o && rsp_ready_i)
                n_responses++;
        end
    end

    function automatic csr_data_t rmw_merge(input csr_cmd_t cmd, input csr_data_t old,
                                            input csr_data_t wdata);
        case (cmd)
            CMD_READ_SET:   return old | wdata;
            CMD_READ_CLEAR: return old & ~wdata;
            default:        return wdata;
        endcase
    endfunction

    function automatic void model_write(input csr_addr_t addr, input csr_data_t data);
        csr_data_t nv;
        nv = '0;
        case (addr)
            ADDR_MSTATUS: begin
                nv[MSTATUS_MIE_BIT]  = data[MSTATUS_MIE_BIT];
                nv[MSTATUS_MPIE_BIT] = data[MSTATUS_MPIE_BIT];
                if (data[MSTATUS_MPP_LSB +: 2] == MPP_RESERVED)
                    nv[MSTATUS_MPP_LSB +: 2] = model[addr][MSTATUS_MPP_LSB +: 2];
                else
                    nv[MSTATUS_MPP_LSB +: 2] = data[MSTATUS_MPP_LSB +: 2];
                model[addr] = nv;
            end
            ADDR_MTVEC, ADDR_MEPC: begin
                if (data[1:0] == 2'b00)
                    model[addr] = data;  // Only aligned targets are kept
            end
            ADDR_MSCRATCH, ADDR_MCAUSE: model[addr] = data;
            ADDR_MIE: begin
                nv[IRQ_EXT_BIT]   = data[IRQ_EXT_BIT];
                nv[IRQ_TIMER_BIT] = data[IRQ_TIMER_BIT];
                nv[IRQ_SW_BIT]    = data[IRQ_SW_BIT];
                model[addr] = nv;
            end
            default: ;
        endcase
    endfunction

    // Lines packed as {ext, timer, sw}
    function automatic csr_data_t mip_expected(input logic [2:0] lines);
        csr_data_t v;
        v = '0;
        v[IRQ_EXT_BIT]   = lines[2];
        v[IRQ_TIMER_BIT] = lines[1];
        v[IRQ_SW_BIT]    = lines[0];
        return v;
    endfunction

    function automatic logic pending_expected(input logic [2:0] lines);
        csr_data_t en;
        en = model[ADDR_MIE];
        return model[ADDR_MSTATUS][MSTATUS_MIE_BIT] &&
            ((en[IRQ_EXT_BIT] && lines[2]) || (en[IRQ_TIMER_BIT] && lines[1]) ||
             (en[IRQ_SW_BIT] && lines[0]));
    endfunction

    task automatic check_value(input string name, input csr_data_t exp, input csr_data_t act);
        if (timeout_hit)
            return;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_cond(input logic cond, input string msg);
        if (timeout_hit)
            return;
        if (cond !== 1'b1) begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic check_rsp(input string name, input csr_data_t exp_data, input logic exp_inv,
                             input csr_rsp_t rsp);
        check_value(name, exp_data, rsp.rdata);
        check_value({name, " invalid"}, csr_data_t'(exp_inv), csr_data_t'(rsp.invalid));
    endtask

    task automatic wait_req_ready(input string name);
        int t;
        if (timeout_hit)
            return;
        t = 0;
        @(negedge clk);
        while (!req_ready_o && t < TIMEOUT_CYC) begin
            @(negedge clk);
            t++;
        end
        if (!req_ready_o) begin
            timeout_hit = 1'b1;
            $display("%s: request not accepted within %0d cycles", name, TIMEOUT_CYC);
        end
    endtask

    task automatic wait_rsp(input string name);
        int t;
        if (timeout_hit)
            return;
        t = 0;
        @(negedge clk);
        while (!(rsp_valid_o && rsp_ready_i) && t < TIMEOUT_CYC) begin
            @(negedge clk);
            t++;
        end
        if (!(rsp_valid_o && rsp_ready_i)) begin
            timeout_hit = 1'b1;
            $display("%s: no response within %0d cycles", name, TIMEOUT_CYC);
        end
    endtask

    // One request that returns in the cycle its response is taken
    task automatic access(input string name, input csr_cmd_t cmd, input csr_addr_t addr,
                          input csr_data_t wdata, output csr_rsp_t rsp);
        rsp = '0;
        if (timeout_hit)
            return;
        @(posedge clk);
        req_valid_i <= 1'b1;
        req_i       <= '{cmd: cmd, addr: addr, wdata: wdata};
        n_issued++;
        wait_req_ready(name);
        @(posedge clk);  // Accept edge
        req_valid_i <= 1'b0;
        wait_rsp(name);
        rsp = rsp_o;
    endtask

    task automatic finish_test(input string name, input int errs_at_start);
        if (timeout_hit) begin
            tests_failed++;
            $display("%s: aborted after timeout", name);
        end else if (errors == errs_at_start) begin
            tests_passed++;
            $display("%s: pass", name);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", name, errors - errs_at_start);
        end
    endtask

    task automatic random_rw_traffic();
        csr_addr_t addrs [5];
        csr_addr_t addr;
        csr_cmd_t  cmd;
        csr_data_t wdata;
        csr_data_t old;
        csr_rsp_t  rsp;
        int        e0;
        e0 = errors;
        addrs = '{ADDR_MSCRATCH, ADDR_MCAUSE, ADDR_MTVEC, ADDR_MEPC, ADDR_MSTATUS};
        repeat (80) begin
            addr  = addrs[$urandom % 5];
            cmd   = csr_cmd_t'(1 + ($urandom % 5));
            wdata = $urandom;
            if ($urandom % 2)
                wdata[1:0] = 2'b00;  // Half the targets aligned
            old = model[addr];
            access("rw_traffic", cmd, addr, wdata, rsp);
            check_rsp("rw_traffic", old, 1'b0, rsp);
            if (cmd != CMD_READ)
                model_write(addr, rmw_merge(cmd, old, wdata));
        end
        // Final readback of every register
        foreach (addrs[i]) begin
            access("rw_readback", CMD_READ, addrs[i], '0, rsp);
            check_rsp("rw_readback", model[addrs[i]], 1'b0, rsp);
        end
        finish_test("rw_traffic", e0);
    endtask

    task automatic id_and_illegal_access();
        csr_addr_t ids [4];
        csr_data_t vals [4];
        csr_rsp_t  rsp;
        int        e0;
        e0 = errors;
        ids  = '{ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID};
        vals = '{MVENDORID_VALUE, MARCHID_VALUE, TB_MIMPID, TB_MHARTID};
        foreach (ids[i]) begin
            access("id_read", CMD_READ, ids[i], '0, rsp);
            check_rsp("id_read", vals[i], 1'b0, rsp);
            access("id_write", CMD_WRITE, ids[i], $urandom, rsp);
            check_value("id_write invalid", 32'd1, csr_data_t'(rsp.invalid));
            access("id_reread", CMD_READ, ids[i], '0, rsp);
            check_rsp("id_reread", vals[i], 1'b0, rsp);
        end
        access("unmapped_read", CMD_READ, 12'h7C0, '0, rsp);
        check_rsp("unmapped_read", '0, 1'b1, rsp);
        access("unmapped_set", CMD_READ_SET, 12'h123, $urandom, rsp);
        check_rsp("unmapped_set", '0, 1'b1, rsp);
        finish_test("id_illegal", e0);
    endtask

    task automatic instret_count();
        csr_rsp_t rsp;
        int       n;
        int       e0;
        e0 = errors;
        n  = 1 + ($urandom % 40);
        access("minstret_clear", CMD_WRITE, ADDR_MINSTRETH, '0, rsp);
        check_value("minstret_clear invalid", '0, csr_data_t'(rsp.invalid));
        access("minstret_clear", CMD_WRITE, ADDR_MINSTRET, '0, rsp);
        check_value("minstret_clear invalid", '0, csr_data_t'(rsp.invalid));
        repeat (n) begin
            @(posedge clk);
            instret_incr_i <= 1'b1;
            @(posedge clk);
            instret_incr_i <= 1'b0;
            repeat ($urandom % 3) @(posedge clk);
        end
        access("minstret_lo", CMD_READ, ADDR_MINSTRET, '0, rsp);
        check_rsp("minstret_lo", csr_data_t'(n), 1'b0, rsp);
        access("minstret_hi", CMD_READ, ADDR_MINSTRETH, '0, rsp);
        check_rsp("minstret_hi", '0, 1'b0, rsp);
        finish_test("minstret", e0);
    endtask

    task automatic cycle_count();
        csr_rsp_t  rsp;
        csr_data_t v;
        csr_data_t r1;
        int        e0;
        e0 = errors;
        v  = $urandom & 32'h0FFF_FFFF;  // Far from low-word wrap
        access("mcycle_write", CMD_WRITE, ADDR_MCYCLEH, '0, rsp);
        access("mcycle_write", CMD_WRITE, ADDR_MCYCLE, v, rsp);
        access("mcycle_read1", CMD_READ, ADDR_MCYCLE, '0, rsp);
        r1 = rsp.rdata;
        check_cond(r1 > v, "mcycle: first read is not above the written value");
        repeat (1 + $urandom % 5) @(posedge clk);
        access("mcycle_read2", CMD_READ, ADDR_MCYCLE, '0, rsp);
        check_cond(rsp.rdata > r1, "mcycle: second read is not above the first read");
        finish_test("mcycle", e0);
    endtask

    task automatic irq_enables();
        csr_rsp_t   rsp;
        csr_cmd_t   cmd;
        csr_data_t  wdata;
        logic [2:0] lines;
        int         e0;
        e0 = errors;
        repeat (16) begin
            lines = 3'($urandom % 8);
            @(posedge clk);
            irq_ext_i   <= lines[2];
            irq_timer_i <= lines[1];
            irq_sw_i    <= lines[0];
            wdata = $urandom;
            access("mie_write", CMD_WRITE, ADDR_MIE, wdata, rsp);
            check_rsp("mie_write", model[ADDR_MIE], 1'b0, rsp);
            model_write(ADDR_MIE, wdata);
            cmd = ($urandom % 2) ? CMD_READ_SET : CMD_READ_CLEAR;
            wdata = 32'd1 << MSTATUS_MIE_BIT;
            access("mstatus_mie", cmd, ADDR_MSTATUS, wdata, rsp);
            check_rsp("mstatus_mie", model[ADDR_MSTATUS], 1'b0, rsp);
            model_write(ADDR_MSTATUS, rmw_merge(cmd, model[ADDR_MSTATUS], wdata));
            @(negedge clk);
            check_value("irq_pending", csr_data_t'(pending_expected(lines)),
                        csr_data_t'(irq_pending_o));
            access("mip_read", CMD_READ, ADDR_MIP, '0, rsp);
            check_rsp("mip_read", mip_expected(lines), 1'b0, rsp);
            access("mip_write", CMD_WRITE, ADDR_MIP, $urandom, rsp);
            check_rsp("mip_write", mip_expected(lines), 1'b0, rsp);
            access("mip_reread", CMD_READ, ADDR_MIP, '0, rsp);
            check_rsp("mip_reread", mip_expected(lines), 1'b0, rsp);
        end
        finish_test("irq", e0);
    endtask

    task automatic response_backpressure();
        csr_rsp_t  first;
        csr_rsp_t  rsp;
        csr_data_t val;
        csr_data_t old;
        int        e0;
        e0  = errors;
        val = $urandom;
        old = model[ADDR_MSCRATCH];
        @(negedge clk);
        bp_random = 1'b0;
        bp_hold   = 1'b0;
        @(posedge clk);  // rsp_ready_i falls here
        req_valid_i <= 1'b1;
        req_i       <= '{cmd: CMD_READ, addr: ADDR_MHARTID, wdata: '0};
        n_issued++;
        wait_req_ready("backpressure");
        @(posedge clk);
        req_i <= '{cmd: CMD_READ_WRITE, addr: ADDR_MSCRATCH, wdata: val};
        n_issued++;
        @(negedge clk);
        first = rsp_o;
        check_cond(rsp_valid_o, "backpressure: first response did not appear");
        check_rsp("backpressure_first", TB_MHARTID, 1'b0, first);
        repeat (6) begin
            @(negedge clk);
            check_cond(rsp_valid_o && (rsp_o == first),
                       "backpressure: response changed while stalled");
            check_cond(!req_ready_o, "backpressure: req_ready_o high while stalled");
        end
        bp_hold = 1'b1;
        wait_req_ready("backpressure");
        bp_hold = 1'b0;  // Drops right after this transfer edge
        @(posedge clk);
        req_valid_i <= 1'b0;
        @(negedge clk);
        check_cond(rsp_valid_o, "backpressure: second response did not appear");
        check_rsp("backpressure_second", old, 1'b0, rsp_o);
        model_write(ADDR_MSCRATCH, val);
        bp_random = 1'b1;
        wait_rsp("backpressure");
        access("backpressure_readback", CMD_READ, ADDR_MSCRATCH, '0, rsp);
        check_rsp("backpressure_readback", model[ADDR_MSCRATCH], 1'b0, rsp);
        @(posedge clk);
        check_value("accepted_count", csr_data_t'(n_issued), csr_data_t'(n_accepted));
        check_value("response_count", csr_data_t'(n_issued), csr_data_t'(n_responses));
        finish_test("backpressure", e0);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n          = 1'b0;
        req_valid_i    = 1'b0;
        req_i          = '0;
        instret_incr_i = 1'b0;
        irq_ext_i      = 1'b0;
        irq_timer_i    = 1'b0;
        irq_sw_i       = 1'b0;
        for (int a = 0; a < 4096; a++)
            model[a] = '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_cond(!rsp_valid_o && !irq_pending_o,
                   "rsp_valid_o or irq_pending_o high after reset");
        bp_random = 1'b1;
        random_rw_traffic();
        id_and_illegal_access();
        instret_count();
        cycle_count();
        irq_enables();
        response_backpressure();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && !timeout_hit)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

// ==== list.f ====
verilog/csr_types_pkg.sv
verilog/csr_map_pkg.sv
verilog/csr_access_ctrl.sv
verilog/csr_machine_regs.sv
verilog/csr_counters.sv
verilog/csr_irq_unit.sv
verilog/csr_top.sv
tb/csr_tb.sv
